// File: all.f
hdl/max_args_pkg.sv
hdl/max_result_if.sv
hdl/max_tracker.sv
hdl/sweep_ctrl.sv
hdl/result_regs.sv
hdl/max_args_top.sv
sim/clk_gen.sv
sim/max_args_tb.sv

// File: sim/max_args_tb.sv
`default_nettype none

module max_args_tb;
    timeunit 1ns;
    timeprecision 10ps;

    import max_args_pkg::*;

    localparam int IN_WIDTH    = 18;
    localparam int RD_TIMEOUT  = 20;
    localparam int RST_TIMEOUT = 100;
    localparam int RAND_SWEEPS = 2;
    localparam int RAND_LEN    = 24;

    typedef struct packed {
        logic [IN_WIDTH-1:0]   r;
        logic [IDX_WIDTH-1:0]  tau;
        logic [IDX_WIDTH-1:0]  freq;
        logic                  sweep_end;
        logic                  clear_first;
        logic [IN_WIDTH-1:0]   exp_max;
        logic [IDX_WIDTH-1:0]  exp_tau;
        logic [IDX_WIDTH-1:0]  exp_freq;
        logic [DATA_WIDTH-1:0] exp_count;
    } row_t;

    logic                  core_clk;
    logic                  resetn;
    logic                  reset_max;
    logic                  we;
    logic [IN_WIDTH-1:0]   r;
    logic [IDX_WIDTH-1:0]  tau;
    logic [IDX_WIDTH-1:0]  freq;
    logic                  rd;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] rdata;
    logic                  rvalid;

    row_t                  rows[$];
    int                    mismatch_count = 0;
    int                    timeout_count  = 0;
    logic [15:0]           lfsr_state = 16'd1;

    // Reference model of the running maximum.
    logic                  m_valid;
    logic [IN_WIDTH-1:0]   m_max;
    logic [IDX_WIDTH-1:0]  m_tau;
    logic [IDX_WIDTH-1:0]  m_freq;
    logic [DATA_WIDTH-1:0] m_count;

    clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(10)) clk0 (
        .core_clk (core_clk),
        .resetn   (resetn)
    );

    max_args_top #(.IN_WIDTH(IN_WIDTH)) dut0 (
        .core_clk  (core_clk),
        .resetn    (resetn),
        .reset_max (reset_max),
        .we        (we),
        .r         (r),
        .tau       (tau),
        .freq      (freq),
        .rd        (rd),
        .addr      (addr),
        .rdata     (rdata),
        .rvalid    (rvalid)
    );

    // x^16 + x^14 + x^13 + x^11 + 1, shifting right.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[0] ^ s[2] ^ s[3] ^ s[5];
        return {fb, s[15:1]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic void add_row(input logic [IN_WIDTH-1:0] s, input logic [15:0] t,
                                    input logic [15:0] f, input logic e, input logic c,
                                    input logic [IN_WIDTH-1:0] em, input logic [15:0] et,
                                    input logic [15:0] ef, input logic [31:0] ec);
        row_t row;
        row = '{s, t, f, e, c, em, et, ef, ec};
        rows.push_back(row);
    endfunction

    // Strictly greater replaces. An empty maximum takes anything.
    function automatic void model_update(input logic [IN_WIDTH-1:0] s,
                                         input logic [15:0] t, input logic [15:0] f);
        if (!m_valid || s > m_max) begin
            m_valid = 1'b1;
            m_max   = s;
            m_tau   = t;
            m_freq  = f;
        end
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge core_clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            mismatch_count++;
            $display("Mismatch at %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic read_word(input logic [ADDR_WIDTH-1:0] a, output logic [31:0] data);
        int cycles;
        @(posedge core_clk);
        #1;
        rd   = 1'b1;
        addr = a;
        @(posedge core_clk);
        #1;
        rd     = 1'b0;
        cycles = 0;
        while (rvalid !== 1'b1 && cycles < RD_TIMEOUT) begin
            @(posedge core_clk);
            #1;
            cycles++;
        end
        data = rdata;
        assert (rvalid === 1'b1) else begin
            timeout_count++;
            $display("Read of address %0d timed out: rvalid never arrived", a);
        end
    endtask

    task automatic read_and_check(input logic [IN_WIDTH-1:0] em, input logic [15:0] et,
                                  input logic [15:0] ef, input logic [31:0] ec);
        logic [31:0] d;
        reg_word_u   w;
        read_word(ADDR_ID, d);
        check_value("ID", d, MAX_ARGS_ID);
        read_word(ADDR_POS, d);
        w.raw = d;
        check_value("POS tau", w.pos.tau, et);
        check_value("POS freq", w.pos.freq, ef);
        read_word(ADDR_MAX, d);
        check_value("MAX", d, em);
        read_word(ADDR_SWEEPS, d);
        check_value("SWEEPS", d, ec);
    endtask

    task automatic pulse_reset_max();
        @(posedge core_clk);
        #1;
        reset_max = 1'b1;
        @(posedge core_clk);
        #1;
        reset_max = 1'b0;
    endtask

    task automatic drive_sample(input logic [IN_WIDTH-1:0] s, input logic [15:0] t,
                                input logic [15:0] f);
        @(posedge core_clk);
        #1;
        we   = 1'b1;
        r    = s;
        tau  = t;
        freq = f;
    endtask

    // Falling we ends the sweep. The snapshot lands two edges later.
    task automatic end_sweep();
        @(posedge core_clk);
        #1;
        we = 1'b0;
        wait_cycles(3);
    endtask

    initial begin
        int                  cycles;
        row_t                row;
        logic [IN_WIDTH-1:0] s;
        logic [31:0]         bits;
        logic [15:0]         t_idx;
        logic [15:0]         f_idx;

        reset_max = 1'b0;
        we        = 1'b0;
        r         = '0;
        tau       = '0;
        freq      = '0;
        rd        = 1'b0;
        addr      = '0;

        // Sweep 1 plain maximum, sweep 2 ties, sweeps 3 and 4 carry across.
        add_row(18'h00100, 16'd1, 16'd10, 0, 0, 18'h00100, 16'd1, 16'd10, 0);
        add_row(18'h02000, 16'd2, 16'd11, 0, 0, 18'h02000, 16'd2, 16'd11, 0);
        add_row(18'h00400, 16'd3, 16'd12, 0, 0, 18'h02000, 16'd2, 16'd11, 0);
        add_row(18'h01fff, 16'd4, 16'd13, 1, 0, 18'h02000, 16'd2, 16'd11, 1);
        add_row(18'h03000, 16'd20, 16'd30, 0, 0, 18'h03000, 16'd20, 16'd30, 1);
        add_row(18'h03000, 16'd21, 16'd31, 0, 0, 18'h03000, 16'd20, 16'd30, 1);
        add_row(18'h00005, 16'd22, 16'd32, 0, 0, 18'h03000, 16'd20, 16'd30, 1);
        add_row(18'h03000, 16'd23, 16'd33, 1, 0, 18'h03000, 16'd20, 16'd30, 2);
        add_row(18'h02fff, 16'd40, 16'd50, 0, 0, 18'h03000, 16'd20, 16'd30, 2);
        add_row(18'h03000, 16'd42, 16'd52, 0, 0, 18'h03000, 16'd20, 16'd30, 2);
        add_row(18'h01000, 16'd41, 16'd51, 1, 0, 18'h03000, 16'd20, 16'd30, 3);
        add_row(18'h3ffff, 16'd60, 16'd70, 0, 0, 18'h3ffff, 16'd60, 16'd70, 3);
        add_row(18'h00000, 16'd61, 16'd71, 1, 0, 18'h3ffff, 16'd60, 16'd70, 4);
        // After reset_max a small value wins again, and a lone zero keeps its place.
        add_row(18'h00010, 16'd80, 16'd90, 0, 1, 18'h00010, 16'd80, 16'd90, 0);
        add_row(18'h00008, 16'd81, 16'd91, 1, 0, 18'h00010, 16'd80, 16'd90, 1);
        add_row(18'h00000, 16'd100, 16'd110, 1, 1, 18'h00000, 16'd100, 16'd110, 1);

        cycles = 0;
        while (resetn !== 1'b1 && cycles < RST_TIMEOUT) begin
            @(posedge core_clk);
            cycles++;
        end
        assert (resetn === 1'b1) else begin
            timeout_count++;
            $display("Reset was never released");
        end
        wait_cycles(2);

        read_and_check('0, '0, '0, '0);

        foreach (rows[i]) begin
            row = rows[i];
            if (row.clear_first) begin
                pulse_reset_max();
                wait_cycles(3);
                read_and_check('0, '0, '0, '0);
            end
            drive_sample(row.r, row.tau, row.freq);
            if (row.sweep_end) begin
                end_sweep();
                read_and_check(row.exp_max, row.exp_tau, row.exp_freq, row.exp_count);
            end
        end

        // Random sweeps start from an empty maximum.
        pulse_reset_max();
        wait_cycles(3);
        m_valid = 1'b0;
        m_max   = '0;
        m_tau   = '0;
        m_freq  = '0;
        m_count = '0;
        for (int sw = 0; sw < RAND_SWEEPS; sw++) begin
            for (int i = 0; i < RAND_LEN; i++) begin
                bits  = random_bits(IN_WIDTH);
                s     = bits[IN_WIDTH-1:0];
                t_idx = 16'(16'h0100 + i);
                f_idx = 16'(16'h8000 + sw * 64 + i);
                drive_sample(s, t_idx, f_idx);
                model_update(s, t_idx, f_idx);
            end
            end_sweep();
            m_count++;
            read_and_check(m_max, m_tau, m_freq, m_count);
        end

        $display("Checks done: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/clk_gen.sv
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic core_clk,
    output logic resetn
);
    timeunit 1ns;
    timeprecision 10ps;

    initial begin
        core_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) core_clk = ~core_clk;
    end

    // Release lines up with the stimulus delay after the edge.
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge core_clk);
        #1 resetn = 1'b1;
    end

endmodule

`default_nettype wire

// File: hdl/max_args_top.sv
`default_nettype none

module max_args_top #(
    parameter int                                  IN_WIDTH = 18,
    parameter logic [max_args_pkg::DATA_WIDTH-1:0] ID       = max_args_pkg::MAX_ARGS_ID
) (
    input  wire                                 core_clk,
    input  wire                                 resetn,
    input  wire                                 reset_max,
    input  wire                                 we,
    input  wire  [IN_WIDTH-1:0]                 r,
    input  wire  [max_args_pkg::IDX_WIDTH-1:0]  tau,
    input  wire  [max_args_pkg::IDX_WIDTH-1:0]  freq,
    input  wire                                 rd,
    input  wire  [max_args_pkg::ADDR_WIDTH-1:0] addr,
    output logic [max_args_pkg::DATA_WIDTH-1:0] rdata,
    output logic                                rvalid
);

    import max_args_pkg::*;

    logic                  clear;
    logic                  snapshot;
    logic [DATA_WIDTH-1:0] sweep_count;

    // Samples must fit in one register word.
    if (IN_WIDTH < 1 || IN_WIDTH > DATA_WIDTH) begin : g_bad_width
        $error("max_args_top: IN_WIDTH out of range");
    end

    max_result_if #(.IN_WIDTH(IN_WIDTH)) res_if ();

    sweep_ctrl u_sweep_ctrl (
        .core_clk    (core_clk),
        .resetn      (resetn),
        .reset_max   (reset_max),
        .we          (we),
        .clear       (clear),
        .snapshot    (snapshot),
        .sweep_count (sweep_count)
    );

    max_tracker #(
        .IN_WIDTH (IN_WIDTH)
    ) u_max_tracker (
        .core_clk (core_clk),
        .resetn   (resetn),
        .clear    (clear),
        .we       (we),
        .r        (r),
        .tau      (tau),
        .freq     (freq),
        .res      (res_if.tracker)
    );

    result_regs #(
        .IN_WIDTH (IN_WIDTH),
        .ID       (ID)
    ) u_result_regs (
        .core_clk    (core_clk),
        .resetn      (resetn),
        .clear       (clear),
        .snapshot    (snapshot),
        .sweep_count (sweep_count),
        .res         (res_if.regs),
        .rd          (rd),
        .addr        (addr),
        .rdata       (rdata),
        .rvalid      (rvalid)
    );

endmodule

`default_nettype wire

// File: hdl/result_regs.sv
`default_nettype none

module result_regs #(
    parameter int                                IN_WIDTH = 18,
    parameter logic [max_args_pkg::DATA_WIDTH-1:0] ID       = max_args_pkg::MAX_ARGS_ID
) (
    input  wire                                 core_clk,
    input  wire                                 resetn,
    input  wire                                 clear,
    input  wire                                 snapshot,
    input  wire  [max_args_pkg::DATA_WIDTH-1:0] sweep_count,
    max_result_if.regs                          res,
    input  wire                                 rd,
    input  wire  [max_args_pkg::ADDR_WIDTH-1:0] addr,
    output logic [max_args_pkg::DATA_WIDTH-1:0] rdata,
    output logic                                rvalid
);

    import max_args_pkg::*;

    logic [IN_WIDTH-1:0]   snap_max;
    logic [IDX_WIDTH-1:0]  snap_tau;
    logic [IDX_WIDTH-1:0]  snap_freq;
    logic [DATA_WIDTH-1:0] snap_sweeps;
    reg_word_u             word;

    // Snapshot of the last completed sweep.
    always_ff @(posedge core_clk or negedge resetn) begin
        if (!resetn) begin
            snap_max    <= '0;
            snap_tau    <= '0;
            snap_freq   <= '0;
            snap_sweeps <= '0;
        end else if (clear) begin
            snap_max    <= '0;
            snap_tau    <= '0;
            snap_freq   <= '0;
            snap_sweeps <= '0;
        end else if (snapshot) begin
            // An empty sweep reports a zero maximum at the origin.
            snap_max    <= res.valid ? res.max_val  : '0;
            snap_tau    <= res.valid ? res.max_tau  : '0;
            snap_freq   <= res.valid ? res.max_freq : '0;
            snap_sweeps <= sweep_count;
        end
    end

    always_comb begin
        word.raw = '0;
        case (addr)
            ADDR_ID: begin
                word.raw = ID;
            end
            ADDR_POS: begin
                word.pos.tau  = snap_tau;
                word.pos.freq = snap_freq;
            end
            ADDR_MAX: begin
                word.raw[IN_WIDTH-1:0] = snap_max;
            end
            default: begin
                word.raw = snap_sweeps;
            end
        endcase
    end

    // Registered read, so a read next to a snapshot sees the old copy.
    always_ff @(posedge core_clk or negedge resetn) begin
        if (!resetn) begin
            rvalid <= 1'b0;
            rdata  <= '0;
        end else begin
            rvalid <= rd;
            if (rd) begin
                rdata <= word.raw;
            end
        end
    end

    a_rvalid_follows_rd : assert property (
        @(posedge core_clk) disable iff (!resetn)
        rd |=> rvalid
    ) else $error("result_regs: rd without rvalid one cycle later");

endmodule

`default_nettype wire

// File: hdl/sweep_ctrl.sv
`default_nettype none

module sweep_ctrl (
    input  wire                                 core_clk,
    input  wire                                 resetn,
    input  wire                                 reset_max,
    input  wire                                 we,
    output logic                                clear,
    output logic                                snapshot,
    output logic [max_args_pkg::DATA_WIDTH-1:0] sweep_count
);

    logic we_q;
    logic we_fall;

    always_ff @(posedge core_clk or negedge resetn) begin
        if (!resetn) begin
            we_q <= 1'b0;
        end else begin
            we_q <= we;
        end
    end

    // End of sweep.
    assign we_fall = we_q && !we;

    // Clear takes priority. A sweep ending under reset_max is dropped.
    always_ff @(posedge core_clk or negedge resetn) begin
        if (!resetn) begin
            clear       <= 1'b0;
            snapshot    <= 1'b0;
            sweep_count <= '0;
        end else if (reset_max) begin
            clear       <= 1'b1;
            snapshot    <= 1'b0;
            sweep_count <= '0;
        end else if (we_fall) begin
            clear       <= 1'b0;
            snapshot    <= 1'b1;
            sweep_count <= sweep_count + 1'b1;
        end else begin
            clear       <= 1'b0;
            snapshot    <= 1'b0;
        end
    end

    a_strobes_exclusive : assert property (
        @(posedge core_clk) disable iff (!resetn)
        !(snapshot && clear)
    ) else $error("sweep_ctrl: snapshot and clear high together");

endmodule

`default_nettype wire

// File: hdl/max_tracker.sv
`default_nettype none

module max_tracker #(
    parameter int IN_WIDTH = 18
) (
    input  wire                               core_clk,
    input  wire                               resetn,
    input  wire                               clear,
    input  wire                               we,
    input  wire  [IN_WIDTH-1:0]               r,
    input  wire  [max_args_pkg::IDX_WIDTH-1:0] tau,
    input  wire  [max_args_pkg::IDX_WIDTH-1:0] freq,
    max_result_if.tracker                     res
);

    logic empty;
    logic take;

    // A clear in this cycle makes the incoming sample the first of a new run.
    assign empty = clear || !res.valid;

    // Strictly greater only, so the first of equal maxima keeps its place.
    assign take = we && (empty || (r > res.max_val));

    always_ff @(posedge core_clk or negedge resetn) begin
        if (!resetn) begin
            res.max_val  <= '0;
            res.max_tau  <= '0;
            res.max_freq <= '0;
            res.valid    <= 1'b0;
        end else if (take) begin
            res.max_val  <= r;
            res.max_tau  <= tau;
            res.max_freq <= freq;
            res.valid    <= 1'b1;
        end else if (clear) begin
            res.max_val  <= '0;
            res.max_tau  <= '0;
            res.max_freq <= '0;
            res.valid    <= 1'b0;
        end
    end

    // Once set, the maximum only empties through a clear strobe.
    a_valid_falls_on_clear : assert property (
        @(posedge core_clk) disable iff (!resetn)
        $fell(res.valid) |-> $past(clear)
    ) else $error("max_tracker: valid dropped without clear");

endmodule

`default_nettype wire

// File: hdl/max_result_if.sv
`default_nettype none

interface max_result_if #(
    parameter int IN_WIDTH = 18
);
    import max_args_pkg::*;

    logic [IN_WIDTH-1:0]  max_val;
    logic [IDX_WIDTH-1:0] max_tau;
    logic [IDX_WIDTH-1:0] max_freq;
    // High once a sample was taken since the last clear.
    logic                 valid;

    modport tracker (
        output max_val, max_tau, max_freq, valid
    );

    modport regs (
        input max_val, max_tau, max_freq, valid
    );

endinterface

`default_nettype wire

// File: hdl/max_args_pkg.sv
`default_nettype none

package max_args_pkg;

    // Index and bus widths.
    localparam int IDX_WIDTH  = 16;
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 2;

    // Register map, word addresses.
    localparam logic [ADDR_WIDTH-1:0] ADDR_ID     = 2'd0;
    localparam logic [ADDR_WIDTH-1:0] ADDR_POS    = 2'd1;
    localparam logic [ADDR_WIDTH-1:0] ADDR_MAX    = 2'd2;
    localparam logic [ADDR_WIDTH-1:0] ADDR_SWEEPS = 2'd3;

    localparam logic [DATA_WIDTH-1:0] MAX_ARGS_ID = 32'h1122_2233;

    // Coordinates of the maximum as packed into one word.
    typedef struct packed {
        logic [IDX_WIDTH-1:0] tau;
        logic [IDX_WIDTH-1:0] freq;
    } pos_word_t;

    // One register word, seen either raw or as a position.
    typedef union packed {
        logic [DATA_WIDTH-1:0] raw;
        pos_word_t             pos;
    } reg_word_u;

endpackage

`default_nettype wire
